// File: Bender.yml
package:
  name: sifh

sources:
  - src/sifhPkg.sv
  - src/coarseHistogram.sv
  - src/peakFinder.sv
  - src/algebraicBlock.sv
  - src/wbThresholdPort.sv
  - src/sifhTop.sv
  - target: test
    files:
      - verif/sifhTb.sv

// File: sim.f
src/sifhPkg.sv
src/coarseHistogram.sv
src/peakFinder.sv
src/algebraicBlock.sv
src/wbThresholdPort.sv
src/sifhTop.sv
verif/sifhTb.sv

// File: src/algebraicBlock.sv
`timescale 1ns/1ns

module algebraicBlock (
    input  logic                          clk,
    input  logic                          res,
    input  logic [sifhPkg::BIN_W-1:0]     peakCH,
    input  logic                          peakDone,
    input  logic [sifhPkg::PIX_W-1:0]     rdPixel,
    output logic [sifhPkg::TS_W-1:0]      winLo,
    output logic [sifhPkg::TS_W-1:0]      winHi,
    output logic [sifhPkg::TS_W-1:0]      peakOff,
    output logic [sifhPkg::BIN_W-1:0]     peakBin,
    output logic                          algebraicReady
);

    logic [sifhPkg::TS_W-1:0]  ch;
    logic [sifhPkg::TS_W-1:0]  lowerBound;
    logic [sifhPkg::TS_W-1:0]  upperBound;
    logic [sifhPkg::TS_W-1:0]  offset;
    logic [sifhPkg::PIX_W-1:0] pixelCount;

    // per-pixel tables
    logic [sifhPkg::TS_W-1:0]  winLoTab   [sifhPkg::PIXEL_NUM];
    logic [sifhPkg::TS_W-1:0]  winHiTab   [sifhPkg::PIXEL_NUM];
    logic [sifhPkg::TS_W-1:0]  peakOffTab [sifhPkg::PIXEL_NUM];
    logic [sifhPkg::BIN_W-1:0] peakBinTab [sifhPkg::PIXEL_NUM];

    // start of the peak bin in timestamp units
    assign ch = sifhPkg::TS_W'(peakCH * sifhPkg::BIN_SPAN);

    always_comb begin
        if (ch <= sifhPkg::HALF_WIN) begin
            lowerBound = '0;                   // clamp at the low edge
            upperBound = sifhPkg::TS_W'(2 * sifhPkg::HALF_WIN);
        end else if (ch >= sifhPkg::TS_MAX - sifhPkg::HALF_WIN) begin
            upperBound = sifhPkg::TS_W'(sifhPkg::TS_MAX); // clamp at the top
            lowerBound = sifhPkg::TS_W'(sifhPkg::TS_MAX - 2 * sifhPkg::HALF_WIN);
        end else begin
            lowerBound = ch - sifhPkg::TS_W'(sifhPkg::HALF_WIN);
            upperBound = ch + sifhPkg::TS_W'(sifhPkg::HALF_WIN);
        end
        offset = ch - lowerBound;              // peak position inside window
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < sifhPkg::PIXEL_NUM; i++) begin
                winLoTab[i]   <= '0;
                winHiTab[i]   <= '0;
                peakOffTab[i] <= '0;
                peakBinTab[i] <= '0;
            end
            pixelCount     <= '0;
            algebraicReady <= 1'b0;
        end else begin
            algebraicReady <= peakDone;
            if (peakDone) begin
                winLoTab[pixelCount]   <= lowerBound;
                winHiTab[pixelCount]   <= upperBound;
                peakOffTab[pixelCount] <= offset;
                peakBinTab[pixelCount] <= peakCH;
                pixelCount             <= pixelCount + 1'b1; // slot 7 wraps to 0
            end
        end
    end

    // table read port
    assign winLo   = winLoTab[rdPixel];
    assign winHi   = winHiTab[rdPixel];
    assign peakOff = peakOffTab[rdPixel];
    assign peakBin = peakBinTab[rdPixel];

endmodule

// File: src/coarseHistogram.sv
`timescale 1ns/1ns

module coarseHistogram (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          tsValid,
    input  logic [sifhPkg::TS_W-1:0]      ts,
    input  logic [sifhPkg::BIN_W-1:0]     binAddr,
    input  logic                          histClear,
    output logic [sifhPkg::CNT_W-1:0]     binCount
);

    logic [sifhPkg::CNT_W-1:0] binCnt [sifhPkg::BIN_NUM];
    logic [sifhPkg::BIN_W-1:0] tsBin;

    // coarse bin is the top bits of the timestamp
    assign tsBin = ts[sifhPkg::TS_W-1 -: sifhPkg::BIN_W];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < sifhPkg::BIN_NUM; i++) begin
                binCnt[i] <= '0;
            end
        end else if (histClear) begin
            for (int i = 0; i < sifhPkg::BIN_NUM; i++) begin
                binCnt[i] <= '0;                  // ready for next frame
            end
        end else if (tsValid) begin
            binCnt[tsBin] <= binCnt[tsBin] + 1'b1; // no saturation needed
        end
    end

    // read port for the peak scan
    assign binCount = binCnt[binAddr];

endmodule

// File: src/peakFinder.sv
`timescale 1ns/1ns

module peakFinder (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          frameEnd,
    input  logic [sifhPkg::CNT_W-1:0]     binCount,
    output logic [sifhPkg::BIN_W-1:0]     binAddr,
    output logic                          histClear,
    output logic [sifhPkg::BIN_W-1:0]     peakCH,
    output logic                          peakDone,
    output logic                          busy
);

    logic                      scanning;
    logic [sifhPkg::CNT_W-1:0] bestCnt;
    logic [sifhPkg::BIN_W-1:0] bestIdx;
    logic                      lastBin;

    assign lastBin = (binAddr == sifhPkg::BIN_W'(sifhPkg::BIN_NUM - 1));

    // idle -> scanning (one bin per cycle) -> done (peakDone high)
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning  <= 1'b0;
            binAddr   <= '0;
            bestCnt   <= '0;
            bestIdx   <= '0;
            peakDone  <= 1'b0;
            histClear <= 1'b0;
            busy      <= 1'b0;
        end else begin
            peakDone  <= 1'b0;
            histClear <= 1'b0;
            if (scanning) begin
                if (binCount > bestCnt) begin   // strict, ties keep lower bin
                    bestCnt <= binCount;
                    bestIdx <= binAddr;
                end
                if (lastBin) begin
                    scanning  <= 1'b0;
                    peakDone  <= 1'b1;
                    histClear <= 1'b1;
                end
                binAddr <= binAddr + 1'b1;     // wraps back to 0
            end else if (peakDone) begin
                busy <= 1'b0;                  // drops with algebraicReady
            end else if (frameEnd && !busy) begin
                scanning <= 1'b1;
                busy     <= 1'b1;
                binAddr  <= '0;
                bestCnt  <= '0;
                bestIdx  <= '0;
            end
        end
    end

    assign peakCH = bestIdx;                   // stable while peakDone is high

endmodule

// File: src/sifhPkg.sv
package sifhPkg;

    // timestamp and coarse bin geometry
    localparam int TS_W     = 10;
    localparam int BIN_W    = 4;
    localparam int BIN_NUM  = 16;
    localparam int BIN_SPAN = 64;                 // timestamps per coarse bin
    localparam int CNT_W    = 8;                  // < 256 hits per frame

    // per-pixel result tables
    localparam int PIXEL_NUM = 8;
    localparam int PIX_W     = 3;

    // fine-search window
    localparam int HALF_WIN = 48;                 // three quarters of a bin
    localparam int TS_MAX   = 1023;

    localparam int WB_DW = 32;

    // window view of a read word
    typedef struct packed {
        logic [WB_DW-16-TS_W-1:0] pad1;
        logic [TS_W-1:0]          hi;             // bits 25..16
        logic [16-TS_W-1:0]       pad0;
        logic [TS_W-1:0]          lo;             // bits 9..0
    } winView_s;

    // peak view of a read word
    typedef struct packed {
        logic [WB_DW-16-BIN_W-1:0] pad1;
        logic [BIN_W-1:0]          bin;           // bits 19..16
        logic [16-TS_W-1:0]        pad0;
        logic [TS_W-1:0]           off;           // bits 9..0
    } peakView_s;

    typedef union packed {
        winView_s  win;
        peakView_s peak;
    } wbWord_u;

endpackage

// File: src/sifhTop.sv
`timescale 1ns/1ns

module sifhTop (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          tsValid,
    input  logic [sifhPkg::TS_W-1:0]      ts,
    input  logic                          frameEnd,
    input  logic                          wbCyc,
    input  logic                          wbStb,
    input  logic                          wbWe,
    input  logic [5:0]                    wbAdr,
    input  logic [sifhPkg::WB_DW-1:0]     wbDatI,
    output logic                          busy,
    output logic                          algebraicReady,
    output logic [sifhPkg::WB_DW-1:0]     wbDatO,
    output logic                          wbAck
);

    logic                      tsAccept;
    logic [sifhPkg::BIN_W-1:0] binAddr;
    logic [sifhPkg::CNT_W-1:0] binCount;
    logic                      histClear;
    logic [sifhPkg::BIN_W-1:0] peakCH;
    logic                      peakDone;
    logic [sifhPkg::PIX_W-1:0] rdPixel;
    logic [sifhPkg::TS_W-1:0]  winLo;
    logic [sifhPkg::TS_W-1:0]  winHi;
    logic [sifhPkg::TS_W-1:0]  peakOff;
    logic [sifhPkg::BIN_W-1:0] peakBin;

    assign tsAccept = tsValid && !busy;        // strobes during a scan are dropped

    coarseHistogram u_coarseHistogram (
        .clk       (clk),
        .res       (res),
        .tsValid   (tsAccept),
        .ts        (ts),
        .binAddr   (binAddr),
        .histClear (histClear),
        .binCount  (binCount)
    );

    peakFinder u_peakFinder (
        .clk       (clk),
        .res       (res),
        .frameEnd  (frameEnd),
        .binCount  (binCount),
        .binAddr   (binAddr),
        .histClear (histClear),
        .peakCH    (peakCH),
        .peakDone  (peakDone),
        .busy      (busy)
    );

    algebraicBlock u_algebraicBlock (
        .clk            (clk),
        .res            (res),
        .peakCH         (peakCH),
        .peakDone       (peakDone),
        .rdPixel        (rdPixel),
        .winLo          (winLo),
        .winHi          (winHi),
        .peakOff        (peakOff),
        .peakBin        (peakBin),
        .algebraicReady (algebraicReady)
    );

    wbThresholdPort u_wbThresholdPort (
        .clk     (clk),
        .res     (res),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbWe    (wbWe),
        .wbAdr   (wbAdr),
        .wbDatI  (wbDatI),
        .winLo   (winLo),
        .winHi   (winHi),
        .peakOff (peakOff),
        .peakBin (peakBin),
        .rdPixel (rdPixel),
        .wbDatO  (wbDatO),
        .wbAck   (wbAck)
    );

endmodule

// File: src/wbThresholdPort.sv
`timescale 1ns/1ns

module wbThresholdPort (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          wbCyc,
    input  logic                          wbStb,
    input  logic                          wbWe,
    input  logic [5:0]                    wbAdr,
    input  logic [sifhPkg::WB_DW-1:0]     wbDatI,
    input  logic [sifhPkg::TS_W-1:0]      winLo,
    input  logic [sifhPkg::TS_W-1:0]      winHi,
    input  logic [sifhPkg::TS_W-1:0]      peakOff,
    input  logic [sifhPkg::BIN_W-1:0]     peakBin,
    output logic [sifhPkg::PIX_W-1:0]     rdPixel,
    output logic [sifhPkg::WB_DW-1:0]     wbDatO,
    output logic                          wbAck
);

    sifhPkg::wbWord_u rdWord;
    logic             peakView;
    logic             request;

    assign rdPixel  = wbAdr[4:2];              // slot select
    assign peakView = wbAdr[5];                // 0 window, 1 peak
    assign request  = wbCyc && wbStb && !wbAck;

    always_comb begin
        rdWord = '0;
        if (peakView) begin
            rdWord.peak.off = peakOff;
            rdWord.peak.bin = peakBin;
        end else begin
            rdWord.win.lo = winLo;
            rdWord.win.hi = winHi;
        end
    end

    // single-cycle ack, one cycle after the request
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= request;
        end
    end

    // read data lines up with ack; write data has nowhere to go
    always_ff @(posedge clk) begin
        if (request && !wbWe) begin
            wbDatO <= rdWord;
        end else if (request) begin
            wbDatO <= '0;                      // writes read back as zero
        end
    end

endmodule

// File: verif/sifhStim.txt
// fields: type_slot_bin_f2_f1_f0, one 48-bit record per line
// 1 timestamp: f1 repeat, f0 ts | 2 filler: f2 top bin, f1 low bin, f0 hits
// 3 frame end | 4 expect: slot, bin, f2 lower, f1 upper, f0 offset | F end
// all slots empty after reset
4_0_0_000_000_000
4_1_0_000_000_000
4_2_0_000_000_000
4_3_0_000_000_000
4_4_0_000_000_000
4_5_0_000_000_000
4_6_0_000_000_000
4_7_0_000_000_000
// frame 1, mid-range peak in bin 7
1_0_0_000_00C_1D0
2_0_0_004_000_006
3_0_0_000_000_000
4_0_7_190_1F0_030
// frame 2, peak in bin 0 clamps low
1_0_0_000_00A_010
2_0_0_00E_003_005
3_0_0_000_000_000
4_1_0_000_060_000
// frame 3, peak in bin 15
1_0_0_000_00A_3F0
2_0_0_00C_000_005
3_0_0_000_000_000
4_2_F_390_3F0_030
// frame 4, bins 5 and 9 tie
1_0_0_000_008_260
1_0_0_000_008_150
2_0_0_00F_00B_004
3_0_0_000_000_000
4_3_5_110_170_030
// frames 5 to 8 fill the remaining slots
1_0_0_000_009_0C5
2_0_0_00F_008_004
3_0_0_000_000_000
4_4_3_090_0F0_030
1_0_0_000_007_05A
2_0_0_00F_004_003
3_0_0_000_000_000
4_5_1_010_070_030
1_0_0_000_009_31F
2_0_0_009_000_005
3_0_0_000_000_000
4_6_C_2D0_330_030
1_0_0_000_008_3A4
2_0_0_00B_000_004
3_0_0_000_000_000
4_7_E_350_3B0_030
// frame 9 wraps back to slot 0
1_0_0_000_00A_2AB
2_0_0_007_000_006
3_0_0_000_000_000
4_0_A_250_2B0_030
// final read-back of every slot
4_0_A_250_2B0_030
4_1_0_000_060_000
4_2_F_390_3F0_030
4_3_5_110_170_030
4_4_3_090_0F0_030
4_5_1_010_070_030
4_6_C_2D0_330_030
4_7_E_350_3B0_030
F_0_0_000_000_000

// File: verif/sifhTb.sv
`timescale 1ns/1ns

module sifhTb;

    localparam int REC_MAX     = 256;
    localparam int READY_DELAY = 18;              // frameEnd to algebraicReady
    localparam int READY_LIMIT = 40;
    localparam int ACK_LIMIT   = 4;

    logic                        clk;
    logic                        res;
    logic                        tsValid;
    logic [sifhPkg::TS_W-1:0]    ts;
    logic                        frameEnd;
    logic                        wbCyc;
    logic                        wbStb;
    logic                        wbWe;
    logic [5:0]                  wbAdr;
    logic [sifhPkg::WB_DW-1:0]   wbDatI;
    logic                        busy;
    logic                        algebraicReady;
    logic [sifhPkg::WB_DW-1:0]   wbDatO;
    logic                        wbAck;

    logic [47:0] stim [REC_MAX];                  // one record per line
    int          recordNum;
    int          checkCount;
    int          valueErrors;
    int          protocolErrors;
    integer      seed;

    sifhTop u_sifhTop (
        .clk            (clk),
        .res            (res),
        .tsValid        (tsValid),
        .ts             (ts),
        .frameEnd       (frameEnd),
        .wbCyc          (wbCyc),
        .wbStb          (wbStb),
        .wbWe           (wbWe),
        .wbAdr          (wbAdr),
        .wbDatI         (wbDatI),
        .busy           (busy),
        .algebraicReady (algebraicReady),
        .wbDatO         (wbDatO),
        .wbAck          (wbAck)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
            valueErrors++;
        end
    endtask

    task automatic driveHits(input logic [11:0] tsVal, input logic [11:0] hits);
        for (int n = 0; n < hits; n++) begin
            tsValid = 1'b1;
            ts      = sifhPkg::TS_W'(tsVal);
            @(negedge clk);
        end
        tsValid = 1'b0;
    endtask

    // random hits spread over bins topBin..lowBin, kept below the peak count
    task automatic driveFiller(input logic [11:0] topBin, input logic [11:0] lowBin,
                               input logic [11:0] hits);
        int span;
        int bin;
        int offs;
        span = topBin - lowBin + 1;
        for (int n = 0; n < hits; n++) begin
            bin     = lowBin + $unsigned($random(seed)) % span;
            offs    = $unsigned($random(seed)) % sifhPkg::BIN_SPAN;
            tsValid = 1'b1;
            ts      = sifhPkg::TS_W'(bin * sifhPkg::BIN_SPAN + offs);
            @(negedge clk);
        end
        tsValid = 1'b0;
    endtask

    task automatic closeFrame();
        int cycles;
        frameEnd = 1'b1;
        @(negedge clk);
        frameEnd = 1'b0;
        cycles   = 1;
        if (!busy) begin
            $display("busy did not rise on the cycle after frameEnd");
            protocolErrors++;
        end
        while (!algebraicReady && cycles < READY_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!algebraicReady) begin
            $display("algebraicReady never came after frameEnd, busy is stuck at %0b", busy);
            protocolErrors++;
        end else begin
            checkValue("readyLatency", cycles, READY_DELAY);
            checkValue("busy", busy, 0);          // falls with the ready pulse
            @(negedge clk);
            checkValue("algebraicReady", algebraicReady, 0);
        end
    endtask

    // one classic cycle; write data is all ones so an effect would show
    task automatic wbAccess(input logic write, input logic [5:0] adr,
                            output logic [31:0] data);
        int waited;
        waited = 0;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = write;
        wbAdr  = adr;
        wbDatI = write ? 32'hFFFF_FFFF : 32'h0;
        @(negedge clk);
        while (!wbAck && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        data  = wbDatO;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        if (!wbAck) begin
            $display("no Wishbone ack for address 0x%h", adr);
            protocolErrors++;
        end else begin
            if (waited != 0) begin
                $display("Wishbone ack came %0d cycles late", waited);
                protocolErrors++;
            end
            @(negedge clk);
            if (wbAck) begin
                $display("Wishbone ack stayed high for more than one cycle");
                protocolErrors++;
            end
        end
    endtask

    task automatic checkSlot(input logic [2:0] slot, input logic [3:0] bin,
                             input logic [11:0] lo, input logic [11:0] hi,
                             input logic [11:0] off);
        logic [31:0] expWin;
        logic [31:0] expPeak;
        logic [31:0] data;
        expWin  = {6'b0, hi[9:0], 6'b0, lo[9:0]};  // hi at 25..16, lo at 9..0
        expPeak = {12'b0, bin, 6'b0, off[9:0]};   // bin at 19..16, offset at 9..0
        wbAccess(1'b0, {1'b0, slot, 2'b00}, data);
        checkValue($sformatf("wbDatO slot %0d window", slot), data, expWin);
        wbAccess(1'b0, {1'b1, slot, 2'b00}, data);
        checkValue($sformatf("wbDatO slot %0d peak", slot), data, expPeak);
        wbAccess(1'b1, {1'b0, slot, 2'b00}, data);
        wbAccess(1'b0, {1'b0, slot, 2'b00}, data);
        checkValue($sformatf("wbDatO slot %0d window after write", slot), data, expWin);
    endtask

    initial begin : watchdog
        wait (recordNum > 0);
        repeat (recordNum * 30 + 200) @(posedge clk);
        $display("watchdog expired after %0d cycles, stimulus not finished",
                 recordNum * 30 + 200);
        $display("Testbench failed");
        $finish;
    end

    initial begin : mainFlow
        int          idx;
        logic [47:0] rec;
        res            = 1'b0;
        tsValid        = 1'b0;
        ts             = '0;
        frameEnd       = 1'b0;
        wbCyc          = 1'b0;
        wbStb          = 1'b0;
        wbWe           = 1'b0;
        wbAdr          = '0;
        wbDatI         = '0;
        recordNum      = 0;
        checkCount     = 0;
        valueErrors    = 0;
        protocolErrors = 0;
        seed           = 32'ha2c8_1d43;
        $readmemh("verif/sifhStim.txt", stim);
        idx = 0;
        while (idx < REC_MAX && stim[idx][47:44] !== 4'hF) begin
            idx++;
        end
        if (idx == REC_MAX) begin
            $display("stimulus file has no end record, nothing was run");
            protocolErrors++;
        end else begin
            recordNum = idx;
        end
        repeat (10) @(negedge clk);
        res = 1'b1;
        @(negedge clk);
        for (idx = 0; idx < recordNum; idx++) begin
            rec = stim[idx];
            case (rec[47:44])
                4'h1: driveHits(rec[11:0], rec[23:12]);
                4'h2: driveFiller(rec[35:24], rec[23:12], rec[11:0]);
                4'h3: closeFrame();
                4'h4: checkSlot(rec[42:40], rec[39:36], rec[35:24], rec[23:12], rec[11:0]);
                default: begin
                    $display("record %0d has an unknown type 0x%h", idx, rec[47:44]);
                    protocolErrors++;
                end
            endcase
        end
        $display("checks run: %0d, value errors: %0d, protocol errors: %0d",
                 checkCount, valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
